// File: radio_pkg.sv
`default_nettype none

package radio_pkg;

   ////////////////////////////////////////
   // Widths and basic types
   ////////////////////////////////////////

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // VITA time and readback word
   typedef logic [63:0] time_t;
   typedef logic [63:0] rb_data_t;

   // One signed I or Q component
   typedef logic signed [15:0] iq_t;

   // I in the upper half, as on the ADC word
   typedef struct packed {
      iq_t i;
      iq_t q;
   } sample_t;

   // Log2 decimation rate, clamped to DECIM_MAX
   typedef logic [2:0] decim_t;
   localparam decim_t DECIM_MAX = 3'd4;

   // Decimator accumulator, 16 bits plus headroom for 16 samples
   localparam int ACC_W = 21;
   typedef logic signed [ACC_W-1:0] acc_t;

   typedef logic [11:0] seqnum_t;
   typedef logic [15:0] spp_t;

   // Packet header on the stream user bus
   typedef struct packed {
      logic [31:0] sid;
      seqnum_t     seqnum;
      logic        eob;
      logic        has_time;
      logic [17:0] spare;
      time_t       tstamp;
   } rx_hdr_t;

   // Receive controller states
   typedef enum logic [1:0] {IDLE, WAIT_TIME, RUNNING} rx_state_t;

   ////////////////////////////////////////
   // Setting addresses
   ////////////////////////////////////////

   localparam set_addr_t SR_TEST     = 8'd7;
   localparam set_addr_t SR_READBACK = 8'd32;
   localparam set_addr_t SR_RX_CTRL  = 8'd96;
   localparam set_addr_t SR_RX_DSP   = 8'd144;
   localparam set_addr_t SR_RX_FRONT = 8'd208;

   // Controller registers, time low write arms the command
   localparam set_addr_t SR_RX_CMD     = SR_RX_CTRL + 8'd0;
   localparam set_addr_t SR_RX_TIME_HI = SR_RX_CTRL + 8'd1;
   localparam set_addr_t SR_RX_TIME_LO = SR_RX_CTRL + 8'd2;
   localparam set_addr_t SR_RX_SID     = SR_RX_CTRL + 8'd3;
   localparam set_addr_t SR_RX_SPP     = SR_RX_CTRL + 8'd4;

   // Front end registers
   localparam set_addr_t SR_RX_OFS_I = SR_RX_FRONT + 8'd0;
   localparam set_addr_t SR_RX_OFS_Q = SR_RX_FRONT + 8'd1;
   localparam set_addr_t SR_RX_SWAP  = SR_RX_FRONT + 8'd2;

endpackage

`default_nettype wire

// File: setting_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One settings-bus register at a fixed address
module setting_reg #(
   parameter radio_pkg::set_addr_t my_addr = 8'd0,
   parameter int                   width   = 32
) (
   input  logic                  radio_clk,
   input  logic                  rst_n,
   input  logic                  set_stb,
   input  radio_pkg::set_addr_t  set_addr,
   input  radio_pkg::set_data_t  set_data,
   output logic [width-1:0]      out
);

   logic hit;

   // Write strobe aimed at this address
   assign hit = set_stb && (set_addr == my_addr);

   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out <= '0;
      end
      else if (hit)
      begin
         // Low bits of the data word only
         out <= set_data[width-1:0];
      end
   end

endmodule

`default_nettype wire

// File: rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frontend (
   input  logic                  radio_clk,
   input  logic                  rst_n,
   input  logic                  set_stb,
   input  radio_pkg::set_addr_t  set_addr,
   input  radio_pkg::set_data_t  set_data,
   input  radio_pkg::sample_t    rx,
   input  logic                  run,
   input  logic                  test_mode,
   output radio_pkg::sample_t    sample,
   output logic                  strobe
);

   radio_pkg::iq_t     ofs_i;
   radio_pkg::iq_t     ofs_q;
   logic               swap;
   radio_pkg::iq_t     ramp_i;
   radio_pkg::sample_t src;
   radio_pkg::sample_t corr;
   radio_pkg::sample_t sample_next;

   // Subtract with clipping to the 16-bit range
   function automatic radio_pkg::iq_t sat_sub(radio_pkg::iq_t a, radio_pkg::iq_t b);
      logic signed [16:0] d;
      d = {a[15], a} - {b[15], b};
      // Sign bits disagree means overflow
      if (d[16] != d[15])
         sat_sub = d[16] ? 16'sh8000 : 16'sh7fff;
      else
         sat_sub = d[15:0];
   endfunction

   ////////////////////////////////////////
   // Front end settings
   ////////////////////////////////////////

   setting_reg #(.my_addr(radio_pkg::SR_RX_OFS_I), .width(16)) sr_ofs_i (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(ofs_i));

   setting_reg #(.my_addr(radio_pkg::SR_RX_OFS_Q), .width(16)) sr_ofs_q (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(ofs_q));

   setting_reg #(.my_addr(radio_pkg::SR_RX_SWAP), .width(1)) sr_swap (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(swap));

   ////////////////////////////////////////
   // Ramp test source and correction
   ////////////////////////////////////////

   // Ramp restarts from 0 on every run
   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
         ramp_i <= '0;
      else
         ramp_i <= run ? ramp_i + 16'sd1 : 16'sd0;
   end

   always_comb
   begin
      // Source select, ramp Q is negated I
      src.i = test_mode ? ramp_i : rx.i;
      src.q = test_mode ? -ramp_i : rx.q;
      // DC offset removal
      corr.i = sat_sub(src.i, ofs_i);
      corr.q = sat_sub(src.q, ofs_q);
      // Optional I/Q swap
      sample_next = swap ? {corr.q, corr.i} : corr;
   end

   // Strobe follows run by one cycle
   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
         strobe <= 1'b0;
      else
         strobe <= run;
   end

   always_ff @(posedge radio_clk)
   begin
      if (run)
         sample <= sample_next;
   end

endmodule

`default_nettype wire

// File: rx_decimator.sv
`timescale 1ns/1ps
`default_nettype none

module rx_decimator (
   input  logic                  radio_clk,
   input  logic                  rst_n,
   input  logic                  set_stb,
   input  radio_pkg::set_addr_t  set_addr,
   input  radio_pkg::set_data_t  set_data,
   input  logic                  run,
   input  radio_pkg::sample_t    in_sample,
   input  logic                  in_strobe,
   output radio_pkg::sample_t    out_sample,
   output logic                  out_strobe
);

   radio_pkg::decim_t rate_set;
   radio_pkg::decim_t rate;
   logic [3:0]        blk_last;
   logic [3:0]        cnt;
   radio_pkg::acc_t   acc_i;
   radio_pkg::acc_t   acc_q;
   radio_pkg::acc_t   in_i;
   radio_pkg::acc_t   in_q;
   radio_pkg::acc_t   sum_i;
   radio_pkg::acc_t   sum_q;
   radio_pkg::acc_t   avg_i;
   radio_pkg::acc_t   avg_q;
   logic              blk_end;

   setting_reg #(.my_addr(radio_pkg::SR_RX_DSP), .width(3)) sr_rate (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(rate_set));

   // Rates above 16x are clamped
   assign rate = (rate_set > radio_pkg::DECIM_MAX) ? radio_pkg::DECIM_MAX : rate_set;
   assign blk_last = 4'((5'd1 << rate) - 5'd1);

   // Sign extend into the accumulator width
   assign in_i = in_sample.i;
   assign in_q = in_sample.q;

   assign sum_i = acc_i + in_i;
   assign sum_q = acc_q + in_q;

   // Divide by the block length
   assign avg_i = sum_i >>> rate;
   assign avg_q = sum_q >>> rate;

   assign blk_end = in_strobe && (cnt == blk_last);

   ////////////////////////////////////////
   // Block accumulate
   ////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt        <= '0;
         acc_i      <= '0;
         acc_q      <= '0;
         out_strobe <= 1'b0;
      end
      else
      begin
         out_strobe <= run && blk_end;
         // Partial block discarded when run drops
         if (!run || blk_end)
         begin
            cnt   <= '0;
            acc_i <= '0;
            acc_q <= '0;
         end
         else if (in_strobe)
         begin
            cnt   <= cnt + 4'd1;
            acc_i <= sum_i;
            acc_q <= sum_q;
         end
      end
   end

   always_ff @(posedge radio_clk)
   begin
      if (run && blk_end)
      begin
         out_sample.i <= avg_i[15:0];
         out_sample.q <= avg_q[15:0];
      end
   end

endmodule

`default_nettype wire

// File: rx_control.sv
`timescale 1ns/1ps
`default_nettype none

module rx_control (
   input  logic                  radio_clk,
   input  logic                  rst_n,
   input  logic                  set_stb,
   input  radio_pkg::set_addr_t  set_addr,
   input  radio_pkg::set_data_t  set_data,
   input  radio_pkg::time_t      vita_time,
   input  radio_pkg::sample_t    sample,
   input  logic                  strobe,
   output logic                  run,
   output logic [31:0]           overflows,
   output radio_pkg::sample_t    rx_tdata,
   output logic                  rx_tlast,
   output logic                  rx_tvalid,
   input  logic                  rx_tready,
   output radio_pkg::rx_hdr_t    rx_tuser
);

   radio_pkg::set_data_t cmd_word;
   logic [31:0]          time_hi;
   logic [31:0]          sid;
   radio_pkg::spp_t      spp;
   radio_pkg::time_t     cmd_time;
   logic                 cmd_cont;
   radio_pkg::rx_state_t state;
   radio_pkg::spp_t      samp_left;
   radio_pkg::spp_t      pkt_cnt;
   radio_pkg::seqnum_t   seqnum;
   logic                 first_pkt;
   logic                 arm;
   logic                 time_reached;
   logic                 take;
   logic                 ovf;
   logic                 accept;
   logic                 final_smp;
   logic                 pkt_first;
   logic                 pkt_end;
   logic [16:0]          pkt_len;
   radio_pkg::rx_hdr_t   hdr_next;

   ////////////////////////////////////////
   // Register decode
   ////////////////////////////////////////

   // Time low write is the arming event
   assign arm = set_stb && (set_addr == radio_pkg::SR_RX_TIME_LO);

   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_word <= '0;
         time_hi  <= '0;
         sid      <= '0;
         spp      <= '0;
         cmd_time <= '0;
         cmd_cont <= 1'b0;
      end
      else if (set_stb)
      begin
         case (set_addr)
            radio_pkg::SR_RX_CMD:     cmd_word <= set_data;
            radio_pkg::SR_RX_TIME_HI: time_hi <= set_data;
            radio_pkg::SR_RX_SID:     sid <= set_data;
            radio_pkg::SR_RX_SPP:     spp <= set_data[15:0];
            radio_pkg::SR_RX_TIME_LO:
            begin
               // Latch the pending command
               cmd_time <= {time_hi, set_data};
               cmd_cont <= cmd_word[30];
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Command FSM
   ////////////////////////////////////////

   assign time_reached = (vita_time >= cmd_time);
   // Timed start raises run in the matching cycle
   assign run = (state == radio_pkg::RUNNING) ||
                ((state == radio_pkg::WAIT_TIME) && time_reached);

   // Samples only count while running
   assign take      = strobe && (state == radio_pkg::RUNNING);
   // Held beat not leaving this cycle
   assign ovf       = take && rx_tvalid && !rx_tready;
   assign accept    = take && !ovf;
   assign final_smp = !cmd_cont && (samp_left == 16'd1);
   assign pkt_first = (pkt_cnt == 16'd0);
   assign pkt_end   = (pkt_cnt == spp - 16'd1) || final_smp;
   // spp of 0 means a full 65536 sample packet
   assign pkt_len   = (spp == 16'd0) ? 17'h10000 : {1'b0, spp};

   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= radio_pkg::IDLE;
      else if (arm)
      begin
         // Stop or empty finite command goes idle
         if (cmd_word[29] || (!cmd_word[30] && cmd_word[15:0] == 16'd0))
            state <= radio_pkg::IDLE;
         else if (cmd_word[31])
            state <= radio_pkg::WAIT_TIME;
         else
            state <= radio_pkg::RUNNING;
      end
      else
      begin
         case (state)
            radio_pkg::WAIT_TIME: if (time_reached) state <= radio_pkg::RUNNING;
            radio_pkg::RUNNING:   if (ovf || (accept && final_smp)) state <= radio_pkg::IDLE;
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Packetizer
   ////////////////////////////////////////

   always_comb
   begin
      hdr_next.sid      = sid;
      hdr_next.seqnum   = seqnum;
      // Packet that reaches the end of a finite command
      hdr_next.eob      = !cmd_cont && ({1'b0, samp_left} <= pkt_len);
      hdr_next.has_time = first_pkt;
      hdr_next.spare    = '0;
      hdr_next.tstamp   = vita_time;
   end

   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         samp_left <= '0;
         pkt_cnt   <= '0;
         seqnum    <= '0;
         first_pkt <= 1'b0;
         overflows <= '0;
      end
      else
      begin
         if (arm)
         begin
            samp_left <= cmd_word[15:0];
            pkt_cnt   <= '0;
            first_pkt <= 1'b1;
         end
         else if (accept)
         begin
            samp_left <= samp_left - 16'd1;
            pkt_cnt   <= pkt_end ? 16'd0 : pkt_cnt + 16'd1;
            // Header taken, move to next sequence number
            if (pkt_first)
            begin
               seqnum    <= seqnum + 12'd1;
               first_pkt <= 1'b0;
            end
         end
         if (ovf)
            overflows <= overflows + 32'd1;
      end
   end

   // Output beat, held until the sink takes it
   always_ff @(posedge radio_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_tvalid <= 1'b0;
         rx_tlast  <= 1'b0;
      end
      else if (accept)
      begin
         rx_tvalid <= 1'b1;
         rx_tlast  <= pkt_end;
      end
      else if (rx_tready)
      begin
         rx_tvalid <= 1'b0;
         rx_tlast  <= 1'b0;
      end
   end

   always_ff @(posedge radio_clk)
   begin
      if (accept)
      begin
         rx_tdata <= sample;
         // User bus changes only at packet start
         if (pkt_first)
            rx_tuser <= hdr_next;
      end
   end

endmodule

`default_nettype wire

// File: radio_rx.sv
`timescale 1ns/1ps
`default_nettype none

// Receive chain at the ADC clock rate
module radio_rx (
   input  logic                  radio_clk,
   input  logic                  rst_n,
   input  radio_pkg::sample_t    rx,
   output logic                  run,
   input  logic                  set_stb,
   input  radio_pkg::set_addr_t  set_addr,
   input  radio_pkg::set_data_t  set_data,
   output radio_pkg::rb_data_t   rb_data,
   input  radio_pkg::time_t      vita_time,
   output radio_pkg::sample_t    rx_tdata,
   output logic                  rx_tlast,
   output logic                  rx_tvalid,
   input  logic                  rx_tready,
   output radio_pkg::rx_hdr_t    rx_tuser
);

   logic               test_mode;
   logic               rb_sel;
   radio_pkg::sample_t fe_sample;
   logic               fe_strobe;
   radio_pkg::sample_t dec_sample;
   logic               dec_strobe;
   logic [31:0]        overflows;

   ////////////////////////////////////////
   // Top level settings
   ////////////////////////////////////////

   // Ramp source in place of the ADC
   setting_reg #(.my_addr(radio_pkg::SR_TEST), .width(1)) sr_test (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(test_mode));

   setting_reg #(.my_addr(radio_pkg::SR_READBACK), .width(1)) sr_readback (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .out(rb_sel));

   ////////////////////////////////////////
   // RX chain
   ////////////////////////////////////////

   rx_frontend u_frontend (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .rx(rx), .run(run),
      .test_mode(test_mode), .sample(fe_sample), .strobe(fe_strobe));

   // Rate 0 is plain pass-through
   rx_decimator u_decimator (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .run(run),
      .in_sample(fe_sample), .in_strobe(fe_strobe),
      .out_sample(dec_sample), .out_strobe(dec_strobe));

   rx_control u_control (
      .radio_clk(radio_clk), .rst_n(rst_n), .set_stb(set_stb),
      .set_addr(set_addr), .set_data(set_data), .vita_time(vita_time),
      .sample(dec_sample), .strobe(dec_strobe), .run(run), .overflows(overflows),
      .rx_tdata(rx_tdata), .rx_tlast(rx_tlast), .rx_tvalid(rx_tvalid),
      .rx_tready(rx_tready), .rx_tuser(rx_tuser));

   // Readback, 0 is time and 1 is overflow count
   always_ff @(posedge radio_clk)
   begin
      rb_data <= rb_sel ? {32'd0, overflows} : vita_time;
   end

endmodule

`default_nettype wire

// File: radio_rx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module radio_rx_asserts (
   input logic               radio_clk,
   input logic               rst_n,
   input radio_pkg::sample_t rx_tdata,
   input logic               rx_tlast,
   input logic               rx_tvalid,
   input logic               rx_tready,
   input radio_pkg::rx_hdr_t rx_tuser
);

   // Failed assertions so far
   int fail_count = 0;

   ////////////////////////////////////////
   // Stream rules
   ////////////////////////////////////////

   // Stalled beat holds data, last and header
   held_beat_stable: assert property (@(posedge radio_clk) disable iff (!rst_n)
      rx_tvalid && !rx_tready |=>
         rx_tvalid && $stable(rx_tdata) && $stable(rx_tlast) && $stable(rx_tuser))
   else
   begin
      fail_count++;
      $error("Stream beat changed while the sink stalled");
   end

   no_valid_in_reset: assert property (@(posedge radio_clk)
      !rst_n |-> rx_tvalid !== 1'b1)
   else
   begin
      fail_count++;
      $error("rx_tvalid high during reset");
   end

   // Last only ever marks a valid beat
   last_needs_valid: assert property (@(posedge radio_clk) disable iff (!rst_n)
      rx_tlast |-> rx_tvalid)
   else
   begin
      fail_count++;
      $error("rx_tlast high without rx_tvalid");
   end

endmodule

bind radio_rx radio_rx_asserts u_asserts (
   .radio_clk(radio_clk), .rst_n(rst_n), .rx_tdata(rx_tdata), .rx_tlast(rx_tlast),
   .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tuser(rx_tuser));

`default_nettype wire

// File: radio_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module radio_rx_tb;

   localparam int CLK_PERIOD = 20;
   // Commanded samples over all tests with continuous runs rounded up
   localparam int SAMPLE_SUM  = 10 + 3 * 4 + 6 + 4 + 64;
   // Largest decimation used is 2^2
   localparam int MAX_DECIM   = 4;
   // Settings writes, timed wait and settle time
   localparam int MARGIN      = 3000;
   localparam int WATCHDOG_NS = (SAMPLE_SUM * MAX_DECIM + MARGIN) * CLK_PERIOD;

   logic                 radio_clk;
   logic                 rst_n;
   radio_pkg::sample_t   rx;
   logic                 run;
   logic                 set_stb;
   radio_pkg::set_addr_t set_addr;
   radio_pkg::set_data_t set_data;
   radio_pkg::rb_data_t  rb_data;
   radio_pkg::time_t     vita_time;
   radio_pkg::sample_t   rx_tdata;
   logic                 rx_tlast;
   logic                 rx_tvalid;
   logic                 rx_tready;
   radio_pkg::rx_hdr_t   rx_tuser;

   // Beats taken off the stream
   radio_pkg::sample_t   beat_data[$];
   logic                 beat_last[$];
   radio_pkg::rx_hdr_t   beat_user[$];

   int                   errors;
   int                   checks;
   string                test_name;
   integer               seed;
   // Run must stay low while vita_time is below this
   radio_pkg::time_t     early_limit;

   radio_rx dut (
      .radio_clk(radio_clk), .rst_n(rst_n), .rx(rx), .run(run),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .rb_data(rb_data), .vita_time(vita_time), .rx_tdata(rx_tdata),
      .rx_tlast(rx_tlast), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
      .rx_tuser(rx_tuser));

   initial
   begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   // Free-running VITA time
   initial
   begin
      vita_time = '0;
      forever
      begin
         @(negedge radio_clk);
         vita_time <= vita_time + 64'd1;
      end
   end

   ////////////////////////////////////////
   // Stream collector and run monitor
   ////////////////////////////////////////

   always @(posedge radio_clk)
   begin
      if (rst_n && rx_tvalid && rx_tready)
      begin
         beat_data.push_back(rx_tdata);
         beat_last.push_back(rx_tlast);
         beat_user.push_back(rx_tuser);
      end
      if (rst_n && run && vita_time < early_limit)
      begin
         $display("%s: run high at time %0d, before command time %0d",
                  test_name, vita_time, early_limit);
         errors++;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic check(input string what, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("[ERROR] %s %s: expected %0h, actual %0h",
                  test_name, what, expected, actual);
      end
   endtask

   // One settings-bus write with the strobe high for a single cycle
   task automatic write_setting(input radio_pkg::set_addr_t addr,
                                input radio_pkg::set_data_t data);
      @(negedge radio_clk);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge radio_clk);
      set_stb  = 1'b0;
   endtask

   // Time low goes last because it arms the command
   task automatic issue_command(input radio_pkg::set_data_t cmd, input radio_pkg::time_t t);
      write_setting(radio_pkg::SR_RX_CMD, cmd);
      write_setting(radio_pkg::SR_RX_TIME_HI, t[63:32]);
      write_setting(radio_pkg::SR_RX_TIME_LO, t[31:0]);
   endtask

   task automatic setup_chain(input logic ramp, input radio_pkg::decim_t rate,
                              input radio_pkg::iq_t ofs_i, input radio_pkg::iq_t ofs_q,
                              input logic swap);
      write_setting(radio_pkg::SR_TEST, {31'd0, ramp});
      write_setting(radio_pkg::SR_RX_DSP, {29'd0, rate});
      write_setting(radio_pkg::SR_RX_OFS_I, {16'd0, ofs_i});
      write_setting(radio_pkg::SR_RX_OFS_Q, {16'd0, ofs_q});
      write_setting(radio_pkg::SR_RX_SWAP, {31'd0, swap});
   endtask

   task automatic clear_beats();
      beat_data.delete();
      beat_last.delete();
      beat_user.delete();
   endtask

   task automatic settle(input int n);
      repeat (n) @(negedge radio_clk);
   endtask

   task automatic wait_beats(input int n, input int limit);
      int cycles;
      cycles = 0;
      while (beat_data.size() < n && cycles < limit)
      begin
         @(negedge radio_clk);
         cycles++;
      end
      if (beat_data.size() < n)
      begin
         $display("%s: only %0d of %0d stream beats arrived in %0d cycles",
                  test_name, beat_data.size(), n, limit);
         errors++;
      end
   endtask

   task automatic wait_run(input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (run !== level && cycles < limit)
      begin
         @(negedge radio_clk);
         cycles++;
      end
      if (run !== level)
      begin
         $display("%s: run did not go to %0b within %0d cycles", test_name, level, limit);
         errors++;
      end
   endtask

   // Offset removal clamped to 16 bits
   function automatic radio_pkg::iq_t clip_sub(input radio_pkg::iq_t a, input radio_pkg::iq_t b);
      int diff;
      diff = int'(a) - int'(b);
      if (diff > 32767)
         diff = 32767;
      else if (diff < -32768)
         diff = -32768;
      return radio_pkg::iq_t'(diff);
   endfunction

   // Average of four ramp values from start with the Q ramp negated
   function automatic int block_avg(input int start, input logic negate);
      int sum;
      sum = 0;
      for (int j = 0; j < 4; j++)
         sum += negate ? -(start + j) : (start + j);
      return sum >>> 2;
   endfunction

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic immediate_capture();
      radio_pkg::seqnum_t exp_seq;
      int                 pkt;
      test_name = "immediate_capture";
      setup_chain(1'b1, 3'd0, 16'sd0, 16'sd0, 1'b0);
      write_setting(radio_pkg::SR_RX_SID, 32'hc0de0011);
      write_setting(radio_pkg::SR_RX_SPP, 32'd4);
      clear_beats();
      issue_command(32'd10, 64'd0);
      wait_beats(10, 100);
      settle(10);
      check("beat count", 10, beat_data.size());
      check("run after count", 0, run);
      if (beat_data.size() == 10)
      begin
         foreach (beat_data[k])
         begin
            pkt     = k / 4;
            // First packets after reset, numbering starts at 0
            exp_seq = 12'(pkt);
            check("tlast", (k % 4 == 3) || (k == 9), beat_last[k]);
            check("q negated", -beat_data[k].i, beat_data[k].q);
            if (k > 0)
               check("ramp step", beat_data[k-1].i + 16'sd1, beat_data[k].i);
            check("sid", 32'hc0de0011, beat_user[k].sid);
            check("seqnum", exp_seq, beat_user[k].seqnum);
            check("has_time", pkt == 0, beat_user[k].has_time);
            check("eob", pkt == 2, beat_user[k].eob);
         end
      end
   endtask

   task automatic frontend_case(input string what, input radio_pkg::sample_t word,
                                input radio_pkg::iq_t ofs_i, input radio_pkg::iq_t ofs_q,
                                input logic swap);
      radio_pkg::iq_t exp_i;
      radio_pkg::iq_t exp_q;
      test_name = what;
      @(negedge radio_clk);
      rx = word;
      setup_chain(1'b0, 3'd0, ofs_i, ofs_q, swap);
      exp_i = swap ? clip_sub(word.q, ofs_q) : clip_sub(word.i, ofs_i);
      exp_q = swap ? clip_sub(word.i, ofs_i) : clip_sub(word.q, ofs_q);
      clear_beats();
      issue_command(32'd4, 64'd0);
      wait_beats(4, 100);
      settle(4);
      check("beat count", 4, beat_data.size());
      foreach (beat_data[k])
      begin
         check("i", exp_i, beat_data[k].i);
         check("q", exp_q, beat_data[k].q);
      end
   endtask

   task automatic frontend_arith();
      radio_pkg::sample_t word;
      radio_pkg::iq_t     ofs_i;
      radio_pkg::iq_t     ofs_q;
      word  = $random(seed);
      ofs_i = radio_pkg::iq_t'($random(seed));
      ofs_q = radio_pkg::iq_t'($random(seed));
      frontend_case("frontend_offset", word, ofs_i, ofs_q, 1'b0);
      // Negative I minus a large offset clips low and positive Q clips high
      word       = $random(seed);
      word.i[15] = 1'b1;
      word.q[15] = 1'b0;
      frontend_case("frontend_clip", word, 16'sh7fff, 16'sh8000, 1'b0);
      word = $random(seed);
      frontend_case("frontend_swap", word, ofs_i, ofs_q, 1'b1);
   endtask

   task automatic decimation();
      int base;
      test_name = "decimation";
      setup_chain(1'b1, 3'd2, 16'sd0, 16'sd0, 1'b0);
      write_setting(radio_pkg::SR_RX_SPP, 32'd8);
      clear_beats();
      issue_command(32'd6, 64'd0);
      wait_beats(6, 200);
      settle(8);
      check("beat count", 6, beat_data.size());
      if (beat_data.size() == 6)
      begin
         // Block start found from the first output
         base = 0;
         for (int s = 15; s >= 0; s--)
            if (block_avg(s, 1'b0) == int'(beat_data[0].i))
               base = s;
         foreach (beat_data[k])
         begin
            check("avg i", block_avg(base + 4 * k, 1'b0), beat_data[k].i);
            check("avg q", block_avg(base + 4 * k, 1'b1), beat_data[k].q);
            check("tlast", k == 5, beat_last[k]);
         end
         check("eob", 1, beat_user[5].eob);
      end
   endtask

   task automatic timed_start();
      radio_pkg::time_t cmd_time;
      test_name = "timed_start";
      setup_chain(1'b1, 3'd0, 16'sd0, 16'sd0, 1'b0);
      write_setting(radio_pkg::SR_RX_SPP, 32'd4);
      clear_beats();
      cmd_time    = vita_time + 64'd200;
      early_limit = cmd_time;
      issue_command(32'h8000_0004, cmd_time);
      wait_beats(4, 400);
      settle(4);
      early_limit = '0;
      check("beat count", 4, beat_data.size());
      if (beat_data.size() > 0)
      begin
         check("has_time", 1, beat_user[0].has_time);
         if (beat_user[0].tstamp < cmd_time)
         begin
            $display("%s: first header time %0d is before command time %0d",
                     test_name, beat_user[0].tstamp, cmd_time);
            errors++;
         end
      end
   endtask

   task automatic overflow();
      test_name = "overflow";
      setup_chain(1'b1, 3'd0, 16'sd0, 16'sd0, 1'b0);
      clear_beats();
      @(negedge radio_clk);
      rx_tready = 1'b0;
      // Continuous capture into a stalled sink
      issue_command(32'h4000_0000, 64'd0);
      wait_run(1'b0, 50);
      settle(4);
      check("run", 0, run);
      check("held beat", 1, rx_tvalid);
      check("beats while stalled", 0, beat_data.size());
      write_setting(radio_pkg::SR_READBACK, 32'd1);
      settle(2);
      check("overflow count", 1, rb_data);
      @(negedge radio_clk);
      rx_tready = 1'b1;
      settle(6);
      check("beats after release", 1, beat_data.size());
      check("valid after drain", 0, rx_tvalid);
   endtask

   task automatic readback_stop();
      radio_pkg::time_t diff;
      test_name = "readback_stop";
      write_setting(radio_pkg::SR_READBACK, 32'd0);
      settle(2);
      diff = vita_time - rb_data;
      if (diff > 64'd3)
      begin
         $display("%s: readback time %0d is not within 3 of bench time %0d",
                  test_name, rb_data, vita_time);
         errors++;
      end
      clear_beats();
      issue_command(32'h4000_0000, 64'd0);
      wait_run(1'b1, 20);
      wait_beats(8, 100);
      // Stop bit ends the continuous run
      issue_command(32'h2000_0000, 64'd0);
      wait_run(1'b0, 20);
      settle(6);
      check("run after stop", 0, run);
      check("valid after stop", 0, rx_tvalid);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      errors      = 0;
      checks      = 0;
      seed        = 32'he5019981;
      early_limit = '0;
      test_name   = "reset";
      rst_n       = 1'b0;
      rx          = '0;
      set_stb     = 1'b0;
      set_addr    = '0;
      set_data    = '0;
      rx_tready   = 1'b1;
      repeat (2) @(negedge radio_clk);
      rst_n = 1'b1;
      check("run", 0, run);
      check("tvalid", 0, rx_tvalid);
      check("tlast", 0, rx_tlast);
      immediate_capture();
      frontend_arith();
      decimation();
      timed_start();
      overflow();
      readback_stop();
      errors += dut.u_asserts.fail_count;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Ends a run that hangs
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, the tests did not finish in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
radio_pkg.sv
setting_reg.sv
rx_frontend.sv
rx_decimator.sv
rx_control.sv
radio_rx.sv
radio_rx_asserts.sv
radio_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the radio_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module radio_rx_tb \
   -f list.f -o radio_rx_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/radio_rx_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
